//--- source/procyon_macros.svh
`ifndef PROCYON_MACROS_SVH
`define PROCYON_MACROS_SVH

// Word sizes
`define DATA_WIDTH 32
`define REG_COUNT  32
`define REG_WIDTH  5

// Reorder buffer depth must be 2**TAG_WIDTH
`define ROB_DEPTH  8
`define TAG_WIDTH  3

`define RS_DEPTH   4

`endif

//--- source/procyon_types.sv
`include "procyon_macros.svh"

`default_nettype none

package procyon_types;

    typedef logic [`DATA_WIDTH-1:0] procyon_data_t;
    typedef logic [`REG_WIDTH-1:0]  procyon_reg_t;
    typedef logic [`TAG_WIDTH-1:0]  procyon_tag_t;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } procyon_alu_func_t;

    typedef enum logic [6:0] {
        OPCODE_OP    = 7'b0110011,
        OPCODE_OPIMM = 7'b0010011
    } procyon_opcode_t;

    typedef struct packed {
        logic [6:0]   funct7;
        procyon_reg_t rs2;
        procyon_reg_t rs1;
        logic [2:0]   funct3;
        procyon_reg_t rd;
        logic [6:0]   opcode;
    } procyon_r_insn_t;

    typedef struct packed {
        logic [11:0]  imm;
        procyon_reg_t rs1;
        logic [2:0]   funct3;
        procyon_reg_t rd;
        logic [6:0]   opcode;
    } procyon_i_insn_t;

    typedef union packed {
        procyon_r_insn_t r;
        procyon_i_insn_t i;
    } procyon_insn_u;

    typedef struct packed {
        logic          rdy;
        procyon_tag_t  tag;
        procyon_data_t data;
    } procyon_src_t;

    // Source 0 is operand a, source 1 is operand b
    typedef struct packed {
        procyon_alu_func_t       func;
        procyon_tag_t            tag;
        procyon_src_t [1:0]      src;
    } procyon_rs_entry_t;

    typedef struct packed {
        logic          valid;
        procyon_tag_t  tag;
        procyon_data_t data;
    } procyon_cdb_t;

    typedef struct packed {
        logic              valid;
        procyon_alu_func_t func;
        procyon_tag_t      tag;
        procyon_data_t     src_a;
        procyon_data_t     src_b;
    } procyon_fu_t;

    typedef struct packed {
        logic          en;
        procyon_reg_t  rdest;
        procyon_data_t data;
    } procyon_retire_t;

endpackage

`default_nettype wire

//--- source/dispatch.sv
`include "procyon_macros.svh"

`default_nettype none

module dispatch (
    input  logic                              clk,
    input  logic                              i_reset,

    input  logic                              i_insn_valid,
    input  procyon_types::procyon_insn_u      i_insn,
    output logic                              o_insn_stall,

    input  logic                              i_rob_full,
    input  procyon_types::procyon_tag_t       i_rob_tag,
    input  logic                              i_rob_src_done [0:1],
    input  procyon_types::procyon_data_t      i_rob_src_data [0:1],
    output logic                              o_rob_alloc_en,
    output logic                              o_rob_alloc_done,
    output procyon_types::procyon_reg_t       o_rob_rdest,

    input  logic                              i_regmap_busy [0:1],
    input  procyon_types::procyon_tag_t       i_regmap_tag  [0:1],
    input  procyon_types::procyon_data_t      i_regmap_data [0:1],
    output procyon_types::procyon_reg_t       o_regmap_rsrc [0:1],
    output logic                              o_regmap_rename_en,
    output procyon_types::procyon_reg_t       o_regmap_rename_rdest,
    output procyon_types::procyon_tag_t       o_regmap_rename_tag,

    input  logic                              i_rs_full,
    input  procyon_types::procyon_cdb_t       i_cdb,
    output logic                              o_rs_en,
    output procyon_types::procyon_rs_entry_t  o_rs_entry
);

    logic                              is_op;
    logic                              is_opimm;
    logic                              is_alu;
    logic                              accept;
    logic                              alt;
    procyon_types::procyon_rs_entry_t  entry;

    always_comb begin
        is_op    = i_insn.r.opcode == procyon_types::OPCODE_OP;
        is_opimm = i_insn.r.opcode == procyon_types::OPCODE_OPIMM;
        is_alu   = is_op || is_opimm;

        o_insn_stall = i_rob_full || i_rs_full;
        accept       = i_insn_valid && !o_insn_stall;

        o_regmap_rsrc[0] = i_insn.r.rs1;
        o_regmap_rsrc[1] = i_insn.r.rs2;

        // SUB only exists as a register op, SRA/SRAI in both forms
        alt = i_insn.r.funct7[5] &&
              ((i_insn.r.funct3 == 3'b101) || (is_op && (i_insn.r.funct3 == 3'b000)));

        entry.func = procyon_types::procyon_alu_func_t'({alt, i_insn.r.funct3});
        entry.tag  = i_rob_tag;

        for (int s = 0; s < 2; s++) begin
            entry.src[s].tag = i_regmap_tag[s];
            if (!i_regmap_busy[s]) begin
                entry.src[s].rdy  = 1'b1;
                entry.src[s].data = i_regmap_data[s];
            end else if (i_rob_src_done[s]) begin
                entry.src[s].rdy  = 1'b1;
                entry.src[s].data = i_rob_src_data[s];
            end else if (i_cdb.valid && (i_cdb.tag == i_regmap_tag[s])) begin
                entry.src[s].rdy  = 1'b1;
                entry.src[s].data = i_cdb.data;
            end else begin
                entry.src[s].rdy  = 1'b0;
                entry.src[s].data = '0;
            end
        end

        if (is_opimm) begin
            entry.src[1].rdy  = 1'b1;
            entry.src[1].tag  = '0;
            entry.src[1].data = {{(`DATA_WIDTH-12){i_insn.i.imm[11]}}, i_insn.i.imm};
        end

        // Unknown opcodes retire straight away as no-ops
        o_rob_alloc_en   = accept;
        o_rob_alloc_done = !is_alu;
        o_rob_rdest      = is_alu ? i_insn.r.rd : '0;

        o_regmap_rename_en    = accept && is_alu && (i_insn.r.rd != '0);
        o_regmap_rename_rdest = i_insn.r.rd;
        o_regmap_rename_tag   = i_rob_tag;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rs_en <= 1'b0;
        end else begin
            o_rs_en <= accept && is_alu;
        end
    end

    always_ff @(posedge clk) begin
        o_rs_entry <= entry;
    end

endmodule

`default_nettype wire

//--- source/register_map.sv
`include "procyon_macros.svh"

`default_nettype none

module register_map (
    input  logic                             clk,
    input  logic                             i_reset,

    input  procyon_types::procyon_reg_t      i_rsrc [0:1],
    output logic                             o_busy [0:1],
    output procyon_types::procyon_tag_t      o_tag  [0:1],
    output procyon_types::procyon_data_t     o_data [0:1],

    input  logic                             i_rename_en,
    input  procyon_types::procyon_reg_t      i_rename_rdest,
    input  procyon_types::procyon_tag_t      i_rename_tag,

    input  procyon_types::procyon_retire_t   i_retire,
    input  procyon_types::procyon_tag_t      i_retire_tag
);

    procyon_types::procyon_data_t  regs [0:`REG_COUNT-1];
    procyon_types::procyon_tag_t   tags [0:`REG_COUNT-1];
    logic [`REG_COUNT-1:0]         busy;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_busy[i] = busy[i_rsrc[i]];
            o_tag[i]  = tags[i_rsrc[i]];
            o_data[i] = regs[i_rsrc[i]];
        end
    end

    // x0 is never written nor renamed, so it stays at reset value
    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy <= '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_retire.en && (i_retire.rdest != '0)) begin
                regs[i_retire.rdest] <= i_retire.data;
                if (busy[i_retire.rdest] && (tags[i_retire.rdest] == i_retire_tag)) begin
                    busy[i_retire.rdest] <= 1'b0;
                end
            end

            // Newer rename overrides the retire clear
            if (i_rename_en && (i_rename_rdest != '0)) begin
                busy[i_rename_rdest] <= 1'b1;
                tags[i_rename_rdest] <= i_rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/reservation_station.sv
`include "procyon_macros.svh"

`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = `RS_DEPTH
) (
    input  logic                              clk,
    input  logic                              i_reset,

    input  logic                              i_rs_en,
    input  procyon_types::procyon_rs_entry_t  i_rs_entry,
    input  procyon_types::procyon_cdb_t       i_cdb,
    output logic                              o_rs_full,

    output procyon_types::procyon_fu_t        o_fu
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    procyon_types::procyon_rs_entry_t   slots [0:RS_DEPTH-1];
    procyon_types::procyon_rs_entry_t   woken [0:RS_DEPTH-1];
    procyon_types::procyon_rs_entry_t   incoming;
    procyon_types::procyon_rs_entry_t   issue_src;
    logic [RS_DEPTH-1:0]                slot_valid;
    logic [IDX_W-1:0]                   issue_idx;
    logic [IDX_W-1:0]                   free_idx;
    logic                               issue_en;
    logic                               issue_incoming;
    logic                               store_en;
    int                                 used;

    logic                               fu_valid;
    procyon_types::procyon_alu_func_t   fu_func;
    procyon_types::procyon_tag_t        fu_tag;
    procyon_types::procyon_data_t       fu_a;
    procyon_types::procyon_data_t       fu_b;

    // Capture a CDB result into any operand still waiting on its tag
    function automatic procyon_types::procyon_rs_entry_t wake(
        input procyon_types::procyon_rs_entry_t entry,
        input procyon_types::procyon_cdb_t      cdb
    );
        procyon_types::procyon_rs_entry_t result;
        result = entry;
        for (int s = 0; s < 2; s++) begin
            if (!entry.src[s].rdy && cdb.valid && (cdb.tag == entry.src[s].tag)) begin
                result.src[s].rdy  = 1'b1;
                result.src[s].data = cdb.data;
            end
        end
        return result;
    endfunction

    always_comb begin
        incoming  = wake(i_rs_entry, i_cdb);
        used      = 0;
        issue_en  = 1'b0;
        issue_idx = '0;
        free_idx  = '0;

        // Walk downwards so the lowest index wins
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            woken[i] = wake(slots[i], i_cdb);
            if (slot_valid[i]) begin
                used = used + 1;
                if (woken[i].src[0].rdy && woken[i].src[1].rdy) begin
                    issue_en  = 1'b1;
                    issue_idx = IDX_W'(i);
                end
            end else begin
                free_idx = IDX_W'(i);
            end
        end

        // A ready new entry may issue directly when no stored one is ready
        issue_incoming = !issue_en && i_rs_en && incoming.src[0].rdy && incoming.src[1].rdy;
        store_en       = i_rs_en && !issue_incoming;
        issue_src      = issue_incoming ? incoming : woken[issue_idx];

        // Keep room for the entry already on its way from dispatch
        o_rs_full = (used + int'(i_rs_en)) >= RS_DEPTH;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            slot_valid <= '0;
            fu_valid   <= 1'b0;
        end else begin
            if (issue_en) begin
                slot_valid[issue_idx] <= 1'b0;
            end
            if (store_en) begin
                slot_valid[free_idx] <= 1'b1;
            end
            fu_valid <= issue_en || issue_incoming;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slots[i] <= woken[i];
        end
        if (store_en) begin
            slots[free_idx] <= incoming;
        end
        fu_func <= issue_src.func;
        fu_tag  <= issue_src.tag;
        fu_a    <= issue_src.src[0].data;
        fu_b    <= issue_src.src[1].data;
    end

    assign o_fu = '{valid: fu_valid, func: fu_func, tag: fu_tag, src_a: fu_a, src_b: fu_b};

endmodule

`default_nettype wire

//--- source/ieu.sv
`default_nettype none

module ieu (
    input  logic                         clk,
    input  logic                         i_reset,

    input  procyon_types::procyon_fu_t   i_fu,
    output procyon_types::procyon_cdb_t  o_cdb
);

    procyon_types::procyon_data_t  result;
    procyon_types::procyon_data_t  cdb_data;
    procyon_types::procyon_tag_t   cdb_tag;
    logic                          cdb_valid;
    logic [4:0]                    shamt;

    assign shamt = i_fu.src_b[4:0];

    always_comb begin
        case (i_fu.func)
            procyon_types::ALU_ADD:  result = i_fu.src_a + i_fu.src_b;
            procyon_types::ALU_SUB:  result = i_fu.src_a - i_fu.src_b;
            procyon_types::ALU_SLL:  result = i_fu.src_a << shamt;
            procyon_types::ALU_SLT:  result = procyon_types::procyon_data_t'(
                                                  $signed(i_fu.src_a) < $signed(i_fu.src_b));
            procyon_types::ALU_SLTU: result = procyon_types::procyon_data_t'(
                                                  i_fu.src_a < i_fu.src_b);
            procyon_types::ALU_XOR:  result = i_fu.src_a ^ i_fu.src_b;
            procyon_types::ALU_SRL:  result = i_fu.src_a >> shamt;
            procyon_types::ALU_SRA:  result = $signed(i_fu.src_a) >>> shamt;
            procyon_types::ALU_OR:   result = i_fu.src_a | i_fu.src_b;
            procyon_types::ALU_AND:  result = i_fu.src_a & i_fu.src_b;
            default:                 result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= i_fu.valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= i_fu.tag;
        cdb_data <= result;
    end

    assign o_cdb = '{valid: cdb_valid, tag: cdb_tag, data: cdb_data};

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
`include "procyon_macros.svh"

`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = `ROB_DEPTH
) (
    input  logic                             clk,
    input  logic                             i_reset,

    input  logic                             i_alloc_en,
    input  procyon_types::procyon_reg_t      i_alloc_rdest,
    input  logic                             i_alloc_done,
    output procyon_types::procyon_tag_t      o_tag,
    output logic                             o_full,

    input  procyon_types::procyon_tag_t      i_src_tag  [0:1],
    output logic                             o_src_done [0:1],
    output procyon_types::procyon_data_t     o_src_data [0:1],

    input  procyon_types::procyon_cdb_t      i_cdb,

    output procyon_types::procyon_retire_t   o_retire,
    output procyon_types::procyon_tag_t      o_retire_tag
);

    procyon_types::procyon_reg_t   rdest_q [0:ROB_DEPTH-1];
    procyon_types::procyon_data_t  data_q  [0:ROB_DEPTH-1];
    logic [ROB_DEPTH-1:0]          done;
    procyon_types::procyon_tag_t   head;
    procyon_types::procyon_tag_t   tail;
    logic [`TAG_WIDTH:0]           count;

    logic                          head_done;
    procyon_types::procyon_data_t  head_data;
    logic                          retire_en;
    logic                          retire_q;
    procyon_types::procyon_reg_t   retire_rdest;
    procyon_types::procyon_data_t  retire_data;

    assign o_tag  = tail;
    assign o_full = count == ROB_DEPTH;

    // Done bits survive retire so the register map can still forward
    // until its rename entry is cleared
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_src_done[i] = done[i_src_tag[i]];
            o_src_data[i] = data_q[i_src_tag[i]];
        end
    end

    // The head may retire on the same edge that its CDB result arrives
    assign head_done = done[head] || (i_cdb.valid && (i_cdb.tag == head));
    assign head_data = done[head] ? data_q[head] : i_cdb.data;
    assign retire_en = (count != '0) && head_done;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            done     <= '0;
            retire_q <= 1'b0;
        end else begin
            if (i_alloc_en) begin
                done[tail] <= i_alloc_done;
                tail       <= tail + 1'b1;
            end
            if (i_cdb.valid) begin
                done[i_cdb.tag] <= 1'b1;
            end
            if (retire_en) begin
                head <= head + 1'b1;
            end
            if (i_alloc_en && !retire_en) begin
                count <= count + 1'b1;
            end else if (!i_alloc_en && retire_en) begin
                count <= count - 1'b1;
            end
            retire_q <= retire_en;
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            rdest_q[tail] <= i_alloc_rdest;
            data_q[tail]  <= '0;
        end
        if (i_cdb.valid) begin
            data_q[i_cdb.tag] <= i_cdb.data;
        end
        retire_rdest <= rdest_q[head];
        retire_data  <= head_data;
        o_retire_tag <= head;
    end

    assign o_retire = '{en: retire_q, rdest: retire_rdest, data: retire_data};

endmodule

`default_nettype wire

//--- source/procyon_backend.sv
`include "procyon_macros.svh"

`default_nettype none

module procyon_backend (
    input  logic                             clk,
    input  logic                             i_reset,

    input  logic                             i_insn_valid,
    input  procyon_types::procyon_insn_u     i_insn,
    output logic                             o_insn_stall,

    output procyon_types::procyon_retire_t   o_retire
);

    logic                              rob_full;
    procyon_types::procyon_tag_t       rob_tag;
    logic                              rob_src_done [0:1];
    procyon_types::procyon_data_t      rob_src_data [0:1];
    logic                              rob_alloc_en;
    logic                              rob_alloc_done;
    procyon_types::procyon_reg_t       rob_rdest;
    procyon_types::procyon_tag_t       rob_retire_tag;

    logic                              regmap_busy [0:1];
    procyon_types::procyon_tag_t       regmap_tag  [0:1];
    procyon_types::procyon_data_t      regmap_data [0:1];
    procyon_types::procyon_reg_t       regmap_rsrc [0:1];
    logic                              regmap_rename_en;
    procyon_types::procyon_reg_t       regmap_rename_rdest;
    procyon_types::procyon_tag_t       regmap_rename_tag;

    logic                              rs_full;
    logic                              rs_en;
    procyon_types::procyon_rs_entry_t  rs_entry;
    procyon_types::procyon_fu_t        fu;
    procyon_types::procyon_cdb_t       cdb;

    // Input side
    dispatch dispatch_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .o_insn_stall(o_insn_stall),
        .i_rob_full(rob_full),
        .i_rob_tag(rob_tag),
        .i_rob_src_done(rob_src_done),
        .i_rob_src_data(rob_src_data),
        .o_rob_alloc_en(rob_alloc_en),
        .o_rob_alloc_done(rob_alloc_done),
        .o_rob_rdest(rob_rdest),
        .i_regmap_busy(regmap_busy),
        .i_regmap_tag(regmap_tag),
        .i_regmap_data(regmap_data),
        .o_regmap_rsrc(regmap_rsrc),
        .o_regmap_rename_en(regmap_rename_en),
        .o_regmap_rename_rdest(regmap_rename_rdest),
        .o_regmap_rename_tag(regmap_rename_tag),
        .i_rs_full(rs_full),
        .i_cdb(cdb),
        .o_rs_en(rs_en),
        .o_rs_entry(rs_entry)
    );

    register_map register_map_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_rsrc(regmap_rsrc),
        .o_busy(regmap_busy),
        .o_tag(regmap_tag),
        .o_data(regmap_data),
        .i_rename_en(regmap_rename_en),
        .i_rename_rdest(regmap_rename_rdest),
        .i_rename_tag(regmap_rename_tag),
        .i_retire(o_retire),
        .i_retire_tag(rob_retire_tag)
    );

    // Processing
    reservation_station #(
        .RS_DEPTH(`RS_DEPTH)
    ) rs_ieu_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_rs_en(rs_en),
        .i_rs_entry(rs_entry),
        .i_cdb(cdb),
        .o_rs_full(rs_full),
        .o_fu(fu)
    );

    ieu ieu_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_fu(fu),
        .o_cdb(cdb)
    );

    // Output side
    reorder_buffer #(
        .ROB_DEPTH(`ROB_DEPTH)
    ) rob_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_alloc_en(rob_alloc_en),
        .i_alloc_rdest(rob_rdest),
        .i_alloc_done(rob_alloc_done),
        .o_tag(rob_tag),
        .o_full(rob_full),
        .i_src_tag(regmap_tag),
        .o_src_done(rob_src_done),
        .o_src_data(rob_src_data),
        .i_cdb(cdb),
        .o_retire(o_retire),
        .o_retire_tag(rob_retire_tag)
    );

endmodule

`default_nettype wire

//--- verification/procyon_backend_tb.sv
`include "procyon_macros.svh"

`default_nettype none

module procyon_backend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSNS      = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSNS * 20 + 100;

    logic                             clk;
    logic                             i_reset;
    logic                             i_insn_valid;
    procyon_types::procyon_insn_u     i_insn;
    logic                             o_insn_stall;
    procyon_types::procyon_retire_t   o_retire;

    procyon_types::procyon_data_t     model_regs [0:`REG_COUNT-1];
    procyon_types::procyon_retire_t   expected_q [$];
    procyon_types::procyon_retire_t   expected_retire;
    logic                             expected_valid;
    int                               error_count;
    int                               accepted_count;
    int                               retired_count;

    procyon_backend procyon_backend_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .o_insn_stall(o_insn_stall),
        .o_retire(o_retire)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // RV32I integer semantics where alt selects SUB or SRA
    function automatic procyon_types::procyon_data_t alu_result(
        input logic [2:0]                   funct3,
        input logic                         alt,
        input procyon_types::procyon_data_t a,
        input procyon_types::procyon_data_t b
    );
        procyon_types::procyon_data_t r;
        logic [4:0]                   sh;
        sh = b[4:0];
        case (funct3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << sh;
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Runs one accepted instruction in program order on the model registers
    function automatic procyon_types::procyon_retire_t execute_insn(
        input procyon_types::procyon_insn_u insn
    );
        procyon_types::procyon_retire_t ret;
        procyon_types::procyon_data_t   a;
        procyon_types::procyon_data_t   b;
        logic                           alt;
        logic                           is_op;
        logic                           is_opimm;
        ret.en    = 1'b1;
        ret.rdest = '0;
        ret.data  = '0;
        is_op     = insn.r.opcode == procyon_types::OPCODE_OP;
        is_opimm  = insn.r.opcode == procyon_types::OPCODE_OPIMM;
        a         = model_regs[insn.r.rs1];
        if (is_op) begin
            b   = model_regs[insn.r.rs2];
            alt = insn.r.funct7[5] && (insn.r.funct3 == 3'b000 || insn.r.funct3 == 3'b101);
        end else begin
            b   = {{20{insn.i.imm[11]}}, insn.i.imm};
            alt = insn.i.imm[10] && (insn.i.funct3 == 3'b101);
        end
        // Anything else is a no-op that retires to x0
        if (is_op || is_opimm) begin
            ret.rdest = insn.r.rd;
            ret.data  = alu_result(insn.r.funct3, alt, a, b);
            if (insn.r.rd != '0) begin
                model_regs[insn.r.rd] = ret.data;
            end
        end
        return ret;
    endfunction

    // Half of the time rs1 reuses the previous destination to build chains
    function automatic procyon_types::procyon_insn_u make_insn(
        input procyon_types::procyon_reg_t prev_rd
    );
        procyon_types::procyon_insn_u insn;
        int                           kind;
        kind       = int'($urandom % 20);
        insn       = procyon_types::procyon_insn_u'($urandom);
        insn.r.rd  = procyon_types::procyon_reg_t'($urandom % 8);
        insn.r.rs1 = ($urandom % 2 == 0) ? prev_rd : procyon_types::procyon_reg_t'($urandom % 8);
        if (kind < 2) begin
            case ($urandom % 4)
                0:       insn.r.opcode = 7'b0000011;
                1:       insn.r.opcode = 7'b0100011;
                2:       insn.r.opcode = 7'b0110111;
                default: insn.r.opcode = 7'b1100011;
            endcase
        end else if (kind < 11) begin
            insn.r.opcode = procyon_types::OPCODE_OP;
            insn.r.rs2    = procyon_types::procyon_reg_t'($urandom % 8);
            insn.r.funct7 = 7'h00;
            if ((insn.r.funct3 == 3'b000 || insn.r.funct3 == 3'b101) && ($urandom % 2 == 1)) begin
                insn.r.funct7 = 7'h20;
            end
        end else begin
            insn.i.opcode = procyon_types::OPCODE_OPIMM;
            if (insn.i.funct3 == 3'b001) begin
                insn.i.imm = {7'h00, insn.i.imm[4:0]};
            end else if (insn.i.funct3 == 3'b101) begin
                insn.i.imm = {(($urandom % 2 == 1) ? 7'h20 : 7'h00), insn.i.imm[4:0]};
            end
        end
        return insn;
    endfunction

    // Holds the instruction until the DUT takes it
    task automatic offer_insn(input procyon_types::procyon_insn_u insn);
        logic taken;
        i_insn_valid = 1'b1;
        i_insn       = insn;
        taken        = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !o_insn_stall;
            @(posedge clk);
            #5;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d  accepted: %0d  retired: %0d",
                 error_count, accepted_count, retired_count);
    endtask

    // Outputs are stable at the falling edge and the assertions sample the rising one
    always @(negedge clk) begin : reference_model
        procyon_types::procyon_retire_t predicted;
        if (!i_reset) begin
            expected_valid = 1'b0;
            if (o_retire.en) begin
                retired_count++;
                if (expected_q.size() != 0) begin
                    expected_retire = expected_q.pop_front();
                    expected_valid  = 1'b1;
                end
            end
            if (i_insn_valid && !o_insn_stall) begin
                predicted = execute_insn(i_insn);
                expected_q.push_back(predicted);
                accepted_count++;
            end
        end
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (i_reset)
        (accepted_count == 0) |-> (!o_retire.en && !o_insn_stall))
    else begin
        error_count++;
        $display("retire or stall raised before any instruction was sent");
    end

    retire_expected: assert property (@(posedge clk) disable iff (i_reset)
        o_retire.en |-> expected_valid)
    else begin
        error_count++;
        $display("retire seen with no instruction left to retire");
    end

    retire_rdest_match: assert property (@(posedge clk) disable iff (i_reset)
        (o_retire.en && expected_valid) |-> (o_retire.rdest == expected_retire.rdest))
    else begin
        error_count++;
        $display("** Error: o_retire.rdest expected 0x%h got 0x%h",
                 $sampled(expected_retire.rdest), $sampled(o_retire.rdest));
    end

    retire_data_match: assert property (@(posedge clk) disable iff (i_reset)
        (o_retire.en && expected_valid) |-> (o_retire.data == expected_retire.data))
    else begin
        error_count++;
        $display("** Error: o_retire.data expected 0x%h got 0x%h",
                 $sampled(expected_retire.data), $sampled(o_retire.data));
    end

    // With every accepted instruction retired both queues are empty
    stall_clear_when_idle: assert property (@(posedge clk) disable iff (i_reset)
        (accepted_count == retired_count) |-> !o_insn_stall)
    else begin
        error_count++;
        $display("o_insn_stall high with no instruction in flight");
    end

    in_flight_bounded: assert property (@(posedge clk) disable iff (i_reset)
        (accepted_count - retired_count) <= `ROB_DEPTH)
    else begin
        error_count++;
        $display("more instructions in flight than the reorder buffer holds");
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        print_counts();
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        procyon_types::procyon_reg_t last_rd;
        int                          sent;
        int                          burst;
        int                          gap;
        void'($urandom(32'h7523_e890));
        i_reset        = 1'b1;
        i_insn_valid   = 1'b0;
        i_insn         = '0;
        expected_valid = 1'b0;
        expected_retire = '0;
        error_count    = 0;
        accepted_count = 0;
        retired_count  = 0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
        end

        repeat (10) @(posedge clk);
        #5;
        i_reset = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #5;
        end

        sent    = 0;
        last_rd = '0;
        while (sent < NUM_INSNS) begin
            burst = 1 + int'($urandom % 12);
            while (burst > 0 && sent < NUM_INSNS) begin
                i_insn  = make_insn(last_rd);
                last_rd = i_insn.r.rd;
                offer_insn(i_insn);
                sent++;
                burst--;
            end
            i_insn_valid = 1'b0;
            i_insn       = procyon_types::procyon_insn_u'($urandom);
            gap          = int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #5;
            end
        end
        i_insn_valid = 1'b0;

        // Let the pipeline drain and then watch for stray retires
        while (retired_count < accepted_count) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);

        queue_drained: assert (expected_q.size() == 0) else begin
            error_count++;
            $display("%0d expected retires never appeared", expected_q.size());
        end
        counts_equal: assert (retired_count == accepted_count) else begin
            error_count++;
            $display("retired %0d instructions but accepted %0d", retired_count, accepted_count);
        end

        print_counts();
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/procyon_types.sv
source/dispatch.sv
source/register_map.sv
source/reservation_station.sv
source/ieu.sv
source/reorder_buffer.sv
source/procyon_backend.sv
verification/procyon_backend_tb.sv

//--- Makefile
TOP = procyon_backend_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
